// File: design/game_cfg.svh
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// Raster geometry, in pixels per line
`define H_TOTAL     64
`define H_VISIBLE   48
`define HS_START    52
`define HS_WIDTH    4

// Raster geometry, in lines per frame
`define V_TOTAL     32
`define V_VISIBLE   24
`define VS_START    26
`define VS_WIDTH    2

// ROM client and SDRAM bank widths
`define SLOT_AW     19
`define BA_AW       22
`define DW          16

// Base of each ROM region inside bank 0
`define MAIN_OFFSET 22'h00_0000
`define SUB_OFFSET  22'h08_0000
`define CHAR_OFFSET 22'h10_0000

`endif

// File: design/game_pkg.sv
package game_pkg;

    // Slot order also gives the arbiter priority, char first
    typedef enum logic [1:0] {
        SLOT_CHAR = 2'd0,
        SLOT_MAIN = 2'd1,
        SLOT_SUB  = 2'd2
    } slot_id_e;

    // Bank 0 read sequence
    typedef enum logic [1:0] {
        ARB_IDLE     = 2'd0,
        ARB_WAIT_ACK = 2'd1,
        ARB_WAIT_DOK = 2'd2
    } arb_state_e;

    // One pulse per SDRAM request, tagged with the slot that won
    typedef struct packed {
        logic     start;
        slot_id_e slot;
    } req_stat_t;

endpackage

// File: design/mem_slot_if.sv
`timescale 1ns/10ps
`include "game_cfg.svh"

interface mem_slot_if;
    logic                cs;
    logic [`SLOT_AW-1:0] addr;
    logic [`DW-1:0]      data;
    logic                ok;

    modport client (
        output cs,
        output addr,
        input  data,
        input  ok
    );

    modport arbiter (
        input  cs,
        input  addr,
        output data,
        output ok
    );

    // Observation only
    modport monitor (
        input  cs,
        input  addr,
        input  data,
        input  ok
    );
endinterface

// File: design/video_timing.sv
`timescale 1ns/10ps
`include "game_cfg.svh"

module video_timing (
    input  logic       clk,
    input  logic       rst_n,
    output logic       pxl2_cen,
    output logic       pxl_cen,
    output logic       hs,
    output logic       vs,
    output logic       lhbl,
    output logic       lvbl,
    output logic       vint,
    output logic [8:0] vrender
);
    localparam logic [8:0] H_LAST   = 9'(`H_TOTAL - 1);
    localparam logic [8:0] H_VIS    = 9'(`H_VISIBLE);
    localparam logic [8:0] HS_FIRST = 9'(`HS_START);
    localparam logic [8:0] HS_END   = 9'(`HS_START + `HS_WIDTH);
    localparam logic [8:0] V_LAST   = 9'(`V_TOTAL - 1);
    localparam logic [8:0] V_VIS    = 9'(`V_VISIBLE);
    localparam logic [8:0] VS_FIRST = 9'(`VS_START);
    localparam logic [8:0] VS_END   = 9'(`VS_START + `VS_WIDTH);

    logic [1:0] phase;
    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic       lvbl_l;

    // Odd phases give pxl2_cen, the last phase also gives pxl_cen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= 2'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            phase    <= phase + 2'd1;
            pxl2_cen <= phase[0];
            pxl_cen  <= &phase;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt   <= 9'd0;
            vcnt   <= 9'd0;
            lvbl_l <= 1'b1;
        end else begin
            lvbl_l <= lvbl;
            if (pxl_cen) begin
                if (hcnt == H_LAST) begin
                    hcnt <= 9'd0;
                    vcnt <= (vcnt == V_LAST) ? 9'd0 : vcnt + 9'd1;
                end else begin
                    hcnt <= hcnt + 9'd1;
                end
            end
        end
    end

    assign lhbl = hcnt < H_VIS;
    assign lvbl = vcnt < V_VIS;
    assign hs   = (hcnt >= HS_FIRST) && (hcnt < HS_END);
    assign vs   = (vcnt >= VS_FIRST) && (vcnt < VS_END);

    // Line being prepared for the next scan
    assign vrender = (vcnt == V_LAST) ? 9'd0 : vcnt + 9'd1;

    // Falling edge of lvbl, one clk wide
    assign vint = lvbl_l & ~lvbl;

    // pxl_cen lands on every other pxl2_cen
    a_cen_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
            pxl_cen |-> pxl2_cen && $past(pxl2_cen, 2) && !$past(pxl_cen, 2)
    );
endmodule

// File: design/rom_slot_arbiter.sv
`timescale 1ns/10ps
`include "game_cfg.svh"

module rom_slot_arbiter
    import game_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    mem_slot_if.arbiter       main_bus,
    mem_slot_if.arbiter       sub_bus,
    mem_slot_if.arbiter       char_bus,
    output logic [`BA_AW-1:0] ba0_addr,
    output logic              ba_rd,
    input  logic              ba_ack,
    input  logic              ba_dok,
    input  logic [`DW-1:0]    data_read,
    output req_stat_t         req_stat
);
    localparam int NSLOT = 3;

    logic [NSLOT-1:0]    cs;
    logic [`SLOT_AW-1:0] addr       [NSLOT];
    logic [`SLOT_AW-1:0] cache_addr [NSLOT];
    logic [`DW-1:0]      cache_data [NSLOT];
    logic [NSLOT-1:0]    valid;
    logic [NSLOT-1:0]    ok;
    logic [NSLOT-1:0]    hit;
    logic [NSLOT-1:0]    miss;
    logic [NSLOT-1:0]    fill_v;

    arb_state_e          state;
    slot_id_e            cur;
    slot_id_e            win;
    logic                any_miss;
    logic                fill;
    logic [`SLOT_AW-1:0] req_addr;
    logic [`BA_AW-1:0]   win_offset;

    // Slot arrays are indexed by slot_id_e
    assign cs[SLOT_CHAR]   = char_bus.cs;
    assign cs[SLOT_MAIN]   = main_bus.cs;
    assign cs[SLOT_SUB]    = sub_bus.cs;
    assign addr[SLOT_CHAR] = char_bus.addr;
    assign addr[SLOT_MAIN] = main_bus.addr;
    assign addr[SLOT_SUB]  = sub_bus.addr;

    assign char_bus.data = cache_data[SLOT_CHAR];
    assign main_bus.data = cache_data[SLOT_MAIN];
    assign sub_bus.data  = cache_data[SLOT_SUB];
    assign char_bus.ok   = ok[SLOT_CHAR];
    assign main_bus.ok   = ok[SLOT_MAIN];
    assign sub_bus.ok    = ok[SLOT_SUB];

    assign fill = (state == ARB_WAIT_DOK) && ba_dok;

    always_comb begin
        for (int i = 0; i < NSLOT; i++) begin
            hit[i]    = cs[i] & valid[i] & (addr[i] == cache_addr[i]);
            miss[i]   = cs[i] & ~hit[i];
            fill_v[i] = fill & (cur == slot_id_e'(i));
        end
    end

    // Fixed priority: char, main, sub
    always_comb begin
        any_miss = 1'b1;
        if (miss[SLOT_CHAR]) begin
            win = SLOT_CHAR;
        end else if (miss[SLOT_MAIN]) begin
            win = SLOT_MAIN;
        end else if (miss[SLOT_SUB]) begin
            win = SLOT_SUB;
        end else begin
            win      = SLOT_CHAR;
            any_miss = 1'b0;
        end
    end

    always_comb begin
        case (win)
            SLOT_MAIN: win_offset = `MAIN_OFFSET;
            SLOT_SUB:  win_offset = `SUB_OFFSET;
            default:   win_offset = `CHAR_OFFSET;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ARB_IDLE;
            cur      <= SLOT_CHAR;
            ba_rd    <= 1'b0;
            req_stat <= '0;
        end else begin
            req_stat.start <= 1'b0;
            case (state)
                ARB_IDLE: if (any_miss) begin
                    cur           <= win;
                    ba_rd         <= 1'b1;
                    req_stat.start <= 1'b1;
                    req_stat.slot <= win;
                    state         <= ARB_WAIT_ACK;
                end
                ARB_WAIT_ACK: if (ba_ack) begin
                    ba_rd <= 1'b0;
                    state <= ARB_WAIT_DOK;
                end
                ARB_WAIT_DOK: if (ba_dok) begin
                    state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // ok follows the hit one cycle later, or the SDRAM data for a fill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ok    <= '0;
            valid <= '0;
        end else begin
            for (int i = 0; i < NSLOT; i++) begin
                ok[i] <= hit[i] | (fill_v[i] & cs[i] & (addr[i] == req_addr));
                if (fill_v[i]) begin
                    valid[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && any_miss) begin
            req_addr <= addr[win];
            ba0_addr <= win_offset + {{(`BA_AW - `SLOT_AW){1'b0}}, addr[win]};
        end
        for (int i = 0; i < NSLOT; i++) begin
            if (fill_v[i]) begin
                cache_addr[i] <= req_addr;
                cache_data[i] <= data_read;
            end
        end
    end

    a_rd_held: assert property (
        @(posedge clk) disable iff (!rst_n) ba_rd && !ba_ack |=> ba_rd
    );

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n) ba_rd && !ba_ack |=> $stable(ba0_addr)
    );
endmodule

// File: design/game_status.sv
`timescale 1ns/10ps

module game_status
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       vint,
    input  req_stat_t  req_stat,
    input  logic [7:0] st_addr,
    output logic [7:0] st_dout
);
    logic [7:0] frame_cnt;
    logic [7:0] miss_cnt [3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= 8'd0;
            miss_cnt  <= '{default: 8'd0};
            st_dout   <= 8'd0;
        end else begin
            if (vint) begin
                frame_cnt <= frame_cnt + 8'd1;
            end
            // One count per SDRAM request, so per cache miss
            if (req_stat.start) begin
                miss_cnt[req_stat.slot] <= miss_cnt[req_stat.slot] + 8'd1;
            end
            case (st_addr[1:0])
                2'd0:    st_dout <= frame_cnt;
                2'd1:    st_dout <= miss_cnt[SLOT_MAIN];
                2'd2:    st_dout <= miss_cnt[SLOT_SUB];
                default: st_dout <= miss_cnt[SLOT_CHAR];
            endcase
        end
    end
endmodule

// File: design/game_top.sv
`timescale 1ns/10ps
`include "game_cfg.svh"

module game_top
    import game_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    // ROM clients
    input  logic                main_cs,
    input  logic                sub_cs,
    input  logic                char_cs,
    input  logic [`SLOT_AW-1:0] main_addr,
    input  logic [`SLOT_AW-1:0] sub_addr,
    input  logic [`SLOT_AW-1:0] char_addr,
    output logic [`DW-1:0]      main_data,
    output logic [`DW-1:0]      sub_data,
    output logic [`DW-1:0]      char_data,
    output logic                main_ok,
    output logic                sub_ok,
    output logic                char_ok,
    // SDRAM bank 0, read only
    output logic [`BA_AW-1:0]   ba0_addr,
    output logic                ba_rd,
    input  logic                ba_ack,
    input  logic                ba_dok,
    input  logic [`DW-1:0]      data_read,
    // Video
    output logic                pxl2_cen,
    output logic                pxl_cen,
    output logic                hs,
    output logic                vs,
    output logic                lhbl,
    output logic                lvbl,
    output logic                vint,
    output logic [8:0]          vrender,
    // Status dump
    input  logic [7:0]          st_addr,
    output logic [7:0]          st_dout
);
    req_stat_t req_stat;

    mem_slot_if main_bus ();
    mem_slot_if sub_bus ();
    mem_slot_if char_bus ();

    assign main_bus.cs   = main_cs;
    assign main_bus.addr = main_addr;
    assign sub_bus.cs    = sub_cs;
    assign sub_bus.addr  = sub_addr;
    assign char_bus.cs   = char_cs;
    assign char_bus.addr = char_addr;

    assign main_data = main_bus.data;
    assign main_ok   = main_bus.ok;
    assign sub_data  = sub_bus.data;
    assign sub_ok    = sub_bus.ok;
    assign char_data = char_bus.data;
    assign char_ok   = char_bus.ok;

    video_timing u_video (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .pxl2_cen   ( pxl2_cen  ),
        .pxl_cen    ( pxl_cen   ),
        .hs         ( hs        ),
        .vs         ( vs        ),
        .lhbl       ( lhbl      ),
        .lvbl       ( lvbl      ),
        .vint       ( vint      ),
        .vrender    ( vrender   )
    );

    rom_slot_arbiter u_arb (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .main_bus   ( main_bus  ),
        .sub_bus    ( sub_bus   ),
        .char_bus   ( char_bus  ),
        .ba0_addr   ( ba0_addr  ),
        .ba_rd      ( ba_rd     ),
        .ba_ack     ( ba_ack    ),
        .ba_dok     ( ba_dok    ),
        .data_read  ( data_read ),
        .req_stat   ( req_stat  )
    );

    game_status u_status (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .vint       ( vint      ),
        .req_stat   ( req_stat  ),
        .st_addr    ( st_addr   ),
        .st_dout    ( st_dout   )
    );
endmodule

// File: verification/game_tests.svh
function automatic logic [`BA_AW-1:0] slot_offset(input int s);
    return (s == 0) ? `MAIN_OFFSET : (s == 1) ? `SUB_OFFSET : `CHAR_OFFSET;
endfunction

// Slot index 0 main, 1 sub, 2 char
task automatic drive_client(input int s, input logic cs, input logic [`SLOT_AW-1:0] a);
    case (s)
        0: begin
            main_cs   = cs;
            main_addr = a;
        end
        1: begin
            sub_cs   = cs;
            sub_addr = a;
        end
        default: begin
            char_cs   = cs;
            char_addr = a;
        end
    endcase
endtask

function automatic logic client_ok(input int s);
    return (s == 0) ? main_ok : (s == 1) ? sub_ok : char_ok;
endfunction

function automatic logic [15:0] client_data(input int s);
    return (s == 0) ? main_data : (s == 1) ? sub_data : char_data;
endfunction

task automatic read_and_check(input int s, input logic [`SLOT_AW-1:0] a, input bit miss);
    int n0;
    int waited;
    logic [`BA_AW-1:0] full;
    n0 = req_log.size();
    full = slot_offset(s) + {3'd0, a};
    drive_client(s, 1'b1, a);
    waited = 0;
    while (!client_ok(s) && waited < 200) begin
        @(negedge clk);
        waited++;
    end
    if (!client_ok(s)) begin
        errors++;
        $display("Slot %0d never raised ok for address %h", s, a);
    end else begin
        check_val("data", bank_word(full), client_data(s));
    end
    if (miss) begin
        check_val("request count", n0 + 1, req_log.size());
        if (req_log.size() > n0) check_val("ba0_addr", full, req_log[n0]);
    end else begin
        check_val("hit latency", 1, waited);
        check_val("request count", n0, req_log.size());
        check_val("ba_rd", 0, ba_rd);
    end
    last_addr[s] = a;
    drive_client(s, 1'b0, a);
    @(negedge clk);
    check_val("ok after release", 0, client_ok(s));
endtask

task automatic raster_timing();
    int gap;
    int n_lhbl;
    int n_hs;
    int n_pxl2;
    int n_both;
    int n_vs;
    int n_vint;
    int exp_line;
    int pix;
    logic lvbl_prev;
    n_lhbl   = 0;
    n_hs     = 0;
    n_pxl2   = 0;
    n_both   = 0;
    n_vs     = 0;
    n_vint   = 0;
    exp_line = -1;
    pix      = 0;
    while (!pxl_cen) @(negedge clk);
    @(negedge clk);
    gap = 1;
    while (!pxl_cen) begin
        @(negedge clk);
        gap++;
    end
    check_val("pxl_cen period", 4, gap);
    repeat (`H_TOTAL * 4) begin
        if (pxl_cen && lhbl) n_lhbl++;
        if (pxl_cen && hs) n_hs++;
        if (pxl2_cen) n_pxl2++;
        if (pxl_cen && pxl2_cen) n_both++;
        @(negedge clk);
    end
    check_val("lhbl pixels", `H_VISIBLE, n_lhbl);
    check_val("hs pixels", `HS_WIDTH, n_hs);
    check_val("pxl2_cen pulses", 2 * `H_TOTAL, n_pxl2);
    check_val("pxl_cen with pxl2_cen", `H_TOTAL, n_both);
    lvbl_prev = lvbl;
    repeat (`V_TOTAL * `H_TOTAL * 4) begin
        @(negedge clk);
        if (pxl_cen && vs) n_vs++;
        if (vint) begin
            n_vint++;
            check_val("lvbl at vint", 0, lvbl);
            check_val("lvbl before vint", 1, lvbl_prev);
            // First blanked line has just started
            exp_line = `V_VISIBLE;
            pix      = 0;
        end
        if (exp_line >= 0) begin
            check_val("vrender", (exp_line + 1) % `V_TOTAL, vrender);
            if (pxl_cen) begin
                pix++;
                if (pix == `H_TOTAL) begin
                    pix      = 0;
                    exp_line = (exp_line + 1) % `V_TOTAL;
                end
            end
        end
        lvbl_prev = lvbl;
    end
    check_val("vint per frame", 1, n_vint);
    check_val("vs pixels", `VS_WIDTH * `H_TOTAL, n_vs);
endtask

task automatic miss_reads();
    read_and_check(0, 19'h0_1234, 1'b1);
    read_and_check(1, 19'h7_0f0f, 1'b1);
    read_and_check(2, 19'h2_abcd, 1'b1);
endtask

task automatic hit_reads();
    read_and_check(0, last_addr[0], 1'b0);
    read_and_check(2, last_addr[2], 1'b0);
    read_and_check(0, 19'h0_1236, 1'b1);
endtask

task automatic priority_order();
    int n0;
    int waited;
    n0 = req_log.size();
    drive_client(0, 1'b1, 19'h1_1111);
    drive_client(1, 1'b1, 19'h2_2222);
    drive_client(2, 1'b1, 19'h3_3333);
    waited = 0;
    while (!(main_ok && sub_ok && char_ok) && waited < 300) begin
        @(negedge clk);
        waited++;
    end
    check_val("all ok", 3'b111, {main_ok, sub_ok, char_ok});
    check_val("main_data", bank_word(`MAIN_OFFSET + 22'h1_1111), main_data);
    check_val("sub_data", bank_word(`SUB_OFFSET + 22'h2_2222), sub_data);
    check_val("char_data", bank_word(`CHAR_OFFSET + 22'h3_3333), char_data);
    if (req_log.size() == n0 + 3) begin
        check_val("first request", `CHAR_OFFSET + 22'h3_3333, req_log[n0]);
        check_val("second request", `MAIN_OFFSET + 22'h1_1111, req_log[n0 + 1]);
        check_val("third request", `SUB_OFFSET + 22'h2_2222, req_log[n0 + 2]);
    end else begin
        errors++;
        $display("Priority test expected 3 requests, saw %0d", req_log.size() - n0);
    end
    last_addr[0] = 19'h1_1111;
    last_addr[1] = 19'h2_2222;
    last_addr[2] = 19'h3_3333;
    main_cs = 0;
    sub_cs  = 0;
    char_cs = 0;
    @(negedge clk);
endtask

task automatic ack_stall();
    int n0;
    int waited;
    logic [`BA_AW-1:0] held;
    n0       = req_log.size();
    held     = `MAIN_OFFSET + 22'h5_0505;
    hold_ack = 1'b1;
    drive_client(0, 1'b1, 19'h5_0505);
    waited = 0;
    while (!ba_rd && waited < 20) begin
        @(negedge clk);
        waited++;
    end
    for (int i = 0; i < 30; i++) begin
        @(negedge clk);
        check_val("ba_rd during stall", 1, ba_rd);
        check_val("ba0_addr during stall", held, ba0_addr);
        check_val("main_ok during stall", 0, main_ok);
        // Cached char address is still served
        if (i == 10) drive_client(2, 1'b1, last_addr[2]);
        if (i == 11) begin
            check_val("char_ok during stall", 1, char_ok);
            check_val("char_data during stall",
                      bank_word(`CHAR_OFFSET + {3'd0, last_addr[2]}), char_data);
            drive_client(2, 1'b0, last_addr[2]);
        end
    end
    hold_ack = 1'b0;
    waited = 0;
    while (!main_ok && waited < 200) begin
        @(negedge clk);
        waited++;
    end
    if (!main_ok) begin
        errors++;
        $display("Stalled main read did not complete after ack was released");
    end else begin
        check_val("main_data after stall", bank_word(held), main_data);
    end
    check_val("request count after stall", n0 + 1, req_log.size());
    if (req_log.size() > n0) begin
        check_val("stalled request", held, req_log[n0]);
    end
    last_addr[0] = 19'h5_0505;
    drive_client(0, 1'b0, 19'h5_0505);
    @(negedge clk);
    check_val("main_ok after release", 0, main_ok);
endtask

task automatic status_dump();
    int exp_miss [3];
    exp_miss = '{0, 0, 0};
    foreach (req_log[i]) begin
        case (req_log[i][20:19])
            2'b00:   exp_miss[0]++;
            2'b01:   exp_miss[1]++;
            default: exp_miss[2]++;
        endcase
    end
    st_addr = 8'd0;
    @(negedge clk);
    check_val("st_dout frames", frames % 256, st_dout);
    for (int s = 1; s < 4; s++) begin
        st_addr = 8'(s);
        @(negedge clk);
        check_val("st_dout misses", exp_miss[s - 1] % 256, st_dout);
    end
endtask

// File: verification/game_tb.sv
`timescale 1ns/10ps
`include "game_cfg.svh"

module game_tb;
    localparam int CYCLE_LIMIT = 40000;

    logic                clk;
    logic                rst_n;
    logic                main_cs;
    logic                sub_cs;
    logic                char_cs;
    logic [`SLOT_AW-1:0] main_addr;
    logic [`SLOT_AW-1:0] sub_addr;
    logic [`SLOT_AW-1:0] char_addr;
    logic [`DW-1:0]      main_data;
    logic [`DW-1:0]      sub_data;
    logic [`DW-1:0]      char_data;
    logic                main_ok;
    logic                sub_ok;
    logic                char_ok;
    logic [`BA_AW-1:0]   ba0_addr;
    logic                ba_rd;
    logic                ba_ack;
    logic                ba_dok;
    logic [`DW-1:0]      data_read;
    logic                pxl2_cen;
    logic                pxl_cen;
    logic                hs;
    logic                vs;
    logic                lhbl;
    logic                lvbl;
    logic                vint;
    logic [8:0]          vrender;
    logic [7:0]          st_addr;
    logic [7:0]          st_dout;

    int                  errors;
    int                  frames;
    int                  cycle_cnt;
    logic                hold_ack;
    logic [31:0]         rng;
    logic [`BA_AW-1:0]   req_log [$];
    logic [`SLOT_AW-1:0] last_addr [3];

    game_top dut_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Bank contents as seen by the SDRAM model
    function automatic logic [15:0] bank_word(input logic [`BA_AW-1:0] a);
        return a[15:0] ^ 16'ha5c3 ^ {10'd0, a[21:16]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // SDRAM bank 0 model with random ack and data delays
    always begin
        @(negedge clk);
        if (rst_n && ba_rd) begin
            req_log.push_back(ba0_addr);
            rng = xorshift(rng);
            repeat (1 + rng % 4) @(negedge clk);
            while (hold_ack) @(negedge clk);
            ba_ack = 1'b1;
            @(negedge clk);
            ba_ack = 1'b0;
            rng = xorshift(rng);
            repeat (1 + rng % 4) @(negedge clk);
            ba_dok    = 1'b1;
            data_read = bank_word(req_log[$]);
            @(negedge clk);
            ba_dok = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (rst_n && vint) begin
            frames++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    `include "game_tests.svh"

    initial begin
        clk       = 0;
        rst_n     = 0;
        errors    = 0;
        frames    = 0;
        cycle_cnt = 0;
        main_cs   = 0;
        sub_cs    = 0;
        char_cs   = 0;
        main_addr = '0;
        sub_addr  = '0;
        char_addr = '0;
        ba_ack    = 0;
        ba_dok    = 0;
        data_read = '0;
        st_addr   = '0;
        hold_ack  = 0;
        rng       = 32'h5d5a_e872;
        repeat (16) @(negedge clk);
        rst_n = 1;
        @(negedge clk);
        raster_timing();
        miss_reads();
        hit_reads();
        priority_order();
        ack_stall();
        status_dump();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

// File: flist.f
+incdir+design
+incdir+verification
design/game_pkg.sv
design/mem_slot_if.sv
design/video_timing.sv
design/rom_slot_arbiter.sv
design/game_status.sv
design/game_top.sv
verification/game_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, then decide the result from the log
cd "$(dirname "$0")" || exit 1
( verilator --binary --timing --top-module game_tb -f flist.f -o game_sim \
    && ./obj_dir/game_sim ) > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
